// ==== cpuConfigPkg.sv ====
package cpuConfigPkg;

    //////////////////////////////////////////////////
    // Datapath sizing
    //////////////////////////////////////////////////

    // Register and memory word width
    localparam int dataWidth = 32;

    // Register index width, 32 registers
    localparam int regAddrWidth = 5;

    // Default word counts for both memories
    localparam int imemDepthDefault = 64;
    localparam int dmemDepthDefault = 64;

    //////////////////////////////////////////////////
    // Common types
    //////////////////////////////////////////////////

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regIdxT;

endpackage

// ==== cpuVectors.txt ====
# I <instruction word, hex>  program word, loaded from address 0 up
# W <test> <register, decimal> <value, hex>  expected writeback, in program order
I 2001000C  addi $1,$0,12
I 2002000A  addi $2,$0,10
I 00221820  add  $3,$1,$2
I 00622022  sub  $4,$3,$2
I 00832824  and  $5,$4,$3
I 00A23025  or   $6,$5,$2
I 0086382A  slt  $7,$4,$6
I 20E8FFFA  addi $8,$7,-6
I 21000064  addi $0,$8,100
I 2109FFFF  addi $9,$8,-1
I 0120502A  slt  $10,$9,$0
I 200B07AB  addi $11,$0,0x7ab
I AC0B0008  sw   $11,8($0)
I 8C0C0008  lw   $12,8($0)
I 018B6820  add  $13,$12,$11
I 118B0002  beq  $12,$11,+2
I 200E0001  addi $14,$0,1
I 200F0002  addi $15,$0,2
I 20100009  addi $16,$0,9
I 12000001  beq  $16,$0,+1
I 2210FFF7  addi $16,$16,-9
I 12000001  beq  $16,$0,+1
I 20110055  addi $17,$0,0x55
I 22120007  addi $18,$16,7
I 0800001B  j    27
I 20130001  addi $19,$0,1
I 20140002  addi $20,$0,2
I 22550020  addi $21,$18,0x20
I 0800001C  j    28
W rtypeChain 1 0000000c
W rtypeChain 2 0000000a
W rtypeChain 3 00000016
W rtypeChain 4 0000000c
W rtypeChain 5 00000004
W rtypeChain 6 0000000e
W rtypeChain 7 00000001
W negImm 8 fffffffb
W negImm 9 fffffffa
W negImm 10 00000001
W loadStore 11 000007ab
W loadStore 12 000007ab
W loadStore 13 00000f56
W branch 16 00000009
W branch 16 00000000
W branch 18 00000007
W jump 21 00000027

// ==== decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit (
    input  logic               Clk,
    input  logic               reset,
    input  cpuConfigPkg::wordT instr,
    input  cpuConfigPkg::wordT pcPlus4,
    output logic               stall,
    output logic               redirect,
    output cpuConfigPkg::wordT redirectPc,
    idExIf.producer            idEx,
    fwdIf.sink                 exMemFwd,
    fwdIf.sink                 memWbFwd
);
    import cpuConfigPkg::*;
    import isaPkg::*;

    opcodeE op;
    functE  fn;
    regIdxT rs;
    regIdxT rt;
    regIdxT rd;
    wordT   imm;
    wordT   rsVal;
    wordT   rtVal;
    ctrlT   ctrl;
    logic   legal;
    logic   isBranch;
    logic   isJump;
    regIdxT exDest;
    logic   loadUse;
    logic   branchHaz;
    wordT   regFile [2**regAddrWidth];

    // Instruction fields
    assign op  = opcodeE'(instr[31:26]);
    assign fn  = functE'(instr[5:0]);
    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = {{(dataWidth-16){instr[15]}}, instr[15:0]};

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////

    always_comb begin
        ctrl     = '0;
        legal    = 1'b1;
        isBranch = 1'b0;
        isJump   = 1'b0;
        case (op)
            opRtype: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (fn)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    // Unknown funct, nop included, does nothing
                    default: begin
                        ctrl  = '0;
                        legal = 1'b0;
                    end
                endcase
            end
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq:   isBranch = 1'b1;
            opJ:     isJump = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////

    // Writeback stage owns the write port
    always_ff @(posedge Clk) begin
        if (memWbFwd.regWrite && memWbFwd.dest != '0) begin
            regFile[memWbFwd.dest] <= memWbFwd.value;
        end
    end

    // $zero reads as zero, same-cycle write bypasses the array
    function automatic wordT readReg(input regIdxT idx);
        if (idx == '0) begin
            return '0;
        end else if (memWbFwd.regWrite && memWbFwd.dest == idx) begin
            return memWbFwd.value;
        end
        return regFile[idx];
    endfunction

    always_comb begin
        rsVal = readReg(rs);
        rtVal = readReg(rt);
    end

    //////////////////////////////////////////////////
    // Hazards and redirect
    //////////////////////////////////////////////////

    // Destination of whatever sits in execute right now
    assign exDest = idEx.ctrl.regDstRd ? idEx.rd : idEx.rt;

    // Load in execute feeding this instruction
    assign loadUse = idEx.valid && idEx.ctrl.memRead && exDest != '0
                     && (exDest == rs || exDest == rt);

    // Branch compares in decode so it waits for in-flight writers
    always_comb begin
        branchHaz = 1'b0;
        if (isBranch) begin
            if (idEx.ctrl.regWrite && exDest != '0 && (exDest == rs || exDest == rt)) begin
                branchHaz = 1'b1;
            end
            if (exMemFwd.regWrite && exMemFwd.dest != '0
                && (exMemFwd.dest == rs || exMemFwd.dest == rt)) begin
                branchHaz = 1'b1;
            end
        end
    end

    assign stall = loadUse || branchHaz;

    // Never redirect on stale operands
    assign redirect = !stall && (isJump || (isBranch && rsVal == rtVal));

    assign redirectPc = isJump ? {pcPlus4[31:28], instr[25:0], 2'b00}
                               : pcPlus4 + (imm << 2);

    //////////////////////////////////////////////////
    // Decode/execute register
    //////////////////////////////////////////////////

    // Stall inserts a bubble
    always_ff @(posedge Clk) begin
        if (reset || stall) begin
            idEx.valid <= 1'b0;
            idEx.ctrl  <= '0;
        end else begin
            idEx.valid <= legal;
            idEx.ctrl  <= ctrl;
        end
    end

    always_ff @(posedge Clk) begin
        idEx.rsVal <= rsVal;
        idEx.rtVal <= rtVal;
        idEx.imm   <= imm;
        idEx.rs    <= rs;
        idEx.rt    <= rt;
        idEx.rd    <= rd;
    end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
    input  logic     Clk,
    input  logic     reset,
    idExIf.consumer  idEx,
    fwdIf.source     exMemFwd,
    fwdIf.sink       memWbFwd,
    exMemIf.producer exMem
);
    import cpuConfigPkg::*;
    import isaPkg::*;

    wordT   opA;
    wordT   fwdB;
    wordT   opB;
    wordT   aluResult;
    regIdxT dest;

    //////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////

    // Nearest producer wins; a load in memory has no data yet
    function automatic wordT pickOperand(input regIdxT src, input wordT regVal);
        if (exMemFwd.regWrite && !exMemFwd.memRead && exMemFwd.dest != '0
            && exMemFwd.dest == src) begin
            return exMemFwd.value;
        end else if (memWbFwd.regWrite && memWbFwd.dest != '0
                     && memWbFwd.dest == src) begin
            return memWbFwd.value;
        end
        return regVal;
    endfunction

    always_comb begin
        opA  = pickOperand(idEx.rs, idEx.rsVal);
        fwdB = pickOperand(idEx.rt, idEx.rtVal);
    end

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    // Immediate for addi, lw and sw
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : fwdB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = ($signed(opA) < $signed(opB)) ? wordT'(1) : '0;
            default: aluResult = '0;
        endcase
    end

    // rd for R-type, rt for immediates
    assign dest = idEx.ctrl.regDstRd ? idEx.rd : idEx.rt;

    //////////////////////////////////////////////////
    // Execute/memory register
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            exMem.valid <= 1'b0;
            exMem.ctrl  <= '0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl  <= idEx.ctrl;
        end
    end

    // Store data is the forwarded rt, not the stale register read
    always_ff @(posedge Clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= fwdB;
        exMem.dest      <= dest;
    end

    // Memory-stage view for forwarding and branch hazards
    assign exMemFwd.regWrite = exMem.valid && exMem.ctrl.regWrite;
    assign exMemFwd.memRead  = exMem.ctrl.memRead;
    assign exMemFwd.dest     = exMem.dest;
    assign exMemFwd.value    = exMem.aluResult;

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit #(
    parameter int imemDepth = cpuConfigPkg::imemDepthDefault
) (
    input  logic                         Clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         redirect,
    input  cpuConfigPkg::wordT           redirectPc,
    input  logic                         imemWrite,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  cpuConfigPkg::wordT           imemData,
    output cpuConfigPkg::wordT           instr,
    output cpuConfigPkg::wordT           pcPlus4
);
    import cpuConfigPkg::*;
    import isaPkg::*;

    localparam int imemIdxWidth = $clog2(imemDepth);

    wordT pc;
    wordT pcNext;
    wordT fetchedInstr;
    wordT imem [imemDepth];

    //////////////////////////////////////////////////
    // Instruction memory
    //////////////////////////////////////////////////

    // Loaded only through the load port while reset is held
    always_ff @(posedge Clk) begin
        if (imemWrite) begin
            imem[imemAddr] <= imemData;
        end
    end

    // Word addressed, low two PC bits ignored
    assign fetchedInstr = imem[pc[imemIdxWidth+1:2]];

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    assign pcNext = redirect ? redirectPc : pc + 32'd4;

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    //////////////////////////////////////////////////
    // Fetch/decode register
    //////////////////////////////////////////////////

    // Redirect squashes the wrong-path word, stall freezes it
    always_ff @(posedge Clk) begin
        if (reset || redirect) begin
            instr   <= nopWord;
            pcPlus4 <= '0;
        end else if (!stall) begin
            instr   <= fetchedInstr;
            pcPlus4 <= pc + 32'd4;
        end
    end

endmodule

// ==== isaPkg.sv ====
package isaPkg;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    // Primary opcode field, bits 31..26
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcodeE;

    // R-type function field, bits 5..0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } functE;

    // ALU operations, add is the zero code so a bubble adds
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpE;

    //////////////////////////////////////////////////
    // Control bundle carried down the pipe
    //////////////////////////////////////////////////

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  regDstRd;
        aluOpE aluOp;
    } ctrlT;

    // sll $0,$0,0 encoding, used as the flush filler
    localparam logic [31:0] nopWord = 32'h0000_0000;

endpackage

// ==== memoryUnit.sv ====
`timescale 1ns/1ps

module memoryUnit #(
    parameter int dmemDepth = cpuConfigPkg::dmemDepthDefault
) (
    input  logic     Clk,
    input  logic     reset,
    exMemIf.consumer exMem,
    fwdIf.source     memWbFwd
);
    import cpuConfigPkg::*;

    localparam int dmemIdxWidth = $clog2(dmemDepth);

    logic [dmemIdxWidth-1:0] wordAddr;
    wordT                    loadData;
    wordT                    dmem [dmemDepth];

    //////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////

    // Byte address to word index
    assign wordAddr = exMem.aluResult[dmemIdxWidth+1:2];

    // Combinational read
    assign loadData = dmem[wordAddr];

    // Bubbles never store
    always_ff @(posedge Clk) begin
        if (exMem.valid && exMem.ctrl.memWrite) begin
            dmem[wordAddr] <= exMem.storeData;
        end
    end

    //////////////////////////////////////////////////
    // Memory/writeback register
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            memWbFwd.regWrite <= 1'b0;
            memWbFwd.memRead  <= 1'b0;
        end else begin
            memWbFwd.regWrite <= exMem.valid && exMem.ctrl.regWrite;
            memWbFwd.memRead  <= exMem.valid && exMem.ctrl.memRead;
        end
    end

    // Write value picked before the register
    always_ff @(posedge Clk) begin
        memWbFwd.dest  <= exMem.dest;
        memWbFwd.value <= exMem.ctrl.memRead ? loadData : exMem.aluResult;
    end

endmodule

// ==== pipeInterfaces.sv ====
`timescale 1ns/1ps

// Decode to execute register contents
interface idExIf;
    import cpuConfigPkg::*;
    import isaPkg::*;

    logic   valid;
    ctrlT   ctrl;
    wordT   rsVal;
    wordT   rtVal;
    wordT   imm;
    regIdxT rs;
    regIdxT rt;
    regIdxT rd;

    modport producer (output valid, ctrl, rsVal, rtVal, imm, rs, rt, rd);
    modport consumer (input valid, ctrl, rsVal, rtVal, imm, rs, rt, rd);
endinterface

// Result of a later stage, for forwarding and hazard checks
interface fwdIf;
    import cpuConfigPkg::*;

    logic   regWrite;
    logic   memRead;
    regIdxT dest;
    wordT   value;

    modport source (output regWrite, memRead, dest, value);
    modport sink (input regWrite, memRead, dest, value);
endinterface

// Execute to memory register contents
interface exMemIf;
    import cpuConfigPkg::*;
    import isaPkg::*;

    logic   valid;
    ctrlT   ctrl;
    wordT   aluResult;
    wordT   storeData;
    regIdxT dest;

    modport producer (output valid, ctrl, aluResult, storeData, dest);
    modport consumer (input valid, ctrl, aluResult, storeData, dest);
endinterface

// ==== pipelineCpu.sv ====
`timescale 1ns/1ps

module pipelineCpu #(
    parameter int imemDepth = cpuConfigPkg::imemDepthDefault,
    parameter int dmemDepth = cpuConfigPkg::dmemDepthDefault
) (
    input  logic                         Clk,
    input  logic                         reset,
    input  logic                         imemWrite,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  cpuConfigPkg::wordT           imemData,
    output logic                         wbValid,
    output cpuConfigPkg::regIdxT         wbReg,
    output cpuConfigPkg::wordT           wbData
);
    import cpuConfigPkg::*;

    // Fetch and decode handshake
    logic stall;
    logic redirect;
    wordT redirectPc;
    wordT instr;
    wordT pcPlus4;

    // Stage to stage bundles
    idExIf  idEx ();
    fwdIf   exMemFwd ();
    fwdIf   memWbFwd ();
    exMemIf exMem ();

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    fetchUnit #(
        .imemDepth(imemDepth)
    ) fetchUnit_inst (
        .Clk        (Clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .imemWrite  (imemWrite),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .instr      (instr),
        .pcPlus4    (pcPlus4)
    );

    decodeUnit decodeUnit_inst (
        .Clk        (Clk),
        .reset      (reset),
        .instr      (instr),
        .pcPlus4    (pcPlus4),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .idEx       (idEx.producer),
        .exMemFwd   (exMemFwd.sink),
        .memWbFwd   (memWbFwd.sink)
    );

    executeUnit executeUnit_inst (
        .Clk      (Clk),
        .reset    (reset),
        .idEx     (idEx.consumer),
        .exMemFwd (exMemFwd.source),
        .memWbFwd (memWbFwd.sink),
        .exMem    (exMem.producer)
    );

    memoryUnit #(
        .dmemDepth(dmemDepth)
    ) memoryUnit_inst (
        .Clk      (Clk),
        .reset    (reset),
        .exMem    (exMem.consumer),
        .memWbFwd (memWbFwd.source)
    );

    //////////////////////////////////////////////////
    // Writeback report
    //////////////////////////////////////////////////

    // Writes to $zero are dropped, so not reported
    assign wbValid = memWbFwd.regWrite && memWbFwd.dest != '0;
    assign wbReg   = memWbFwd.dest;
    assign wbData  = memWbFwd.value;

endmodule

// ==== tbPipelineCpu.sv ====
`timescale 1ns/1ps

module tbPipelineCpu;
    import cpuConfigPkg::*;

    localparam int imemDepth    = imemDepthDefault;
    localparam int dmemDepth    = dmemDepthDefault;
    localparam int imemIdxWidth = $clog2(imemDepth);
    // Cycles allowed between two expected writes
    localparam int writeTimeout = 200;
    // Quiet cycles watched after the last expected write
    localparam int drainCycles  = 40;
    localparam int resetHold    = 5;

    typedef logic [imemIdxWidth-1:0] imemIdxT;

    logic    Clk;
    logic    reset;
    logic    imemWrite;
    imemIdxT imemAddr;
    wordT    imemData;
    logic    wbValid;
    regIdxT  wbReg;
    wordT    wbData;

    // Program words and expected writes, in file order
    wordT   progWords [$];
    regIdxT expReg [$];
    wordT   expData [$];
    string  expTest [$];

    int   errorCount;
    int   checkCount;
    int   testCount;
    int   failedTests;
    logic timedOut;

    pipelineCpu #(
        .imemDepth(imemDepth),
        .dmemDepth(dmemDepth)
    ) pipelineCpu_inst (
        .Clk       (Clk),
        .reset     (reset),
        .imemWrite (imemWrite),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .wbValid   (wbValid),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    // 4 ns period
    always #2 Clk = ~Clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic compareValue(input string name, input wordT actual, input wordT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Tag I is a program word, tag W an expected write
    task automatic readVectors();
        int    fd;
        int    regNum;
        string line;
        string name;
        wordT  word;
        fd = $fopen("cpuVectors.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open cpuVectors.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) == "I") begin
                if ($sscanf(line, "I %h", word) == 1) begin
                    progWords.push_back(word);
                end else begin
                    errorCount++;
                    $display("Unreadable program line in cpuVectors.txt: %s", line);
                end
            end else if (line.len() > 0 && line.getc(0) == "W") begin
                if ($sscanf(line, "W %s %d %h", name, regNum, word) == 3) begin
                    expTest.push_back(name);
                    expReg.push_back(regIdxT'(regNum));
                    expData.push_back(word);
                end else begin
                    errorCount++;
                    $display("Unreadable expected-write line in cpuVectors.txt: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // Sampled at the falling edge, away from input and register updates
    task automatic waitWrite(output logic arrived);
        int cycles;
        arrived = 1'b0;
        cycles  = 0;
        while (!arrived && cycles < writeTimeout) begin
            @(negedge Clk);
            cycles++;
            if (wbValid === 1'b1) begin
                arrived = 1'b1;
            end
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore, input int writes);
        testCount++;
        if (errorCount != errorsBefore) begin
            failedTests++;
            $display("test %s: FAIL, %0d errors over %0d writes", name,
                     errorCount - errorsBefore, writes);
        end else begin
            $display("test %s: pass, %0d writes", name, writes);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////

    initial begin
        int    idx;
        int    errorsBefore;
        int    writes;
        logic  arrived;
        string curTest;
        Clk         = 1'b0;
        reset       = 1'b1;
        imemWrite   = 1'b0;
        imemAddr    = '0;
        imemData    = '0;
        errorCount  = 0;
        checkCount  = 0;
        testCount   = 0;
        failedTests = 0;
        timedOut    = 1'b0;

        readVectors();
        if (progWords.size() == 0 || expReg.size() == 0) begin
            errorCount++;
            $display("Vector file gave no program words or no expected writes");
        end

        // Program load while reset is held, no report may appear
        errorsBefore = errorCount;
        for (idx = 0; idx < progWords.size(); idx++) begin
            @(posedge Clk);
            #0.5;
            imemWrite = 1'b1;
            imemAddr  = imemIdxT'(idx);
            imemData  = progWords[idx];
            @(negedge Clk);
            compareValue("wbValid", wordT'(wbValid), '0);
        end
        // Then the reset hold proper
        for (idx = 0; idx < resetHold; idx++) begin
            @(posedge Clk);
            #0.5;
            imemWrite = 1'b0;
            @(negedge Clk);
            compareValue("wbValid", wordT'(wbValid), '0);
        end
        reportTest("resetQuiet", errorsBefore, 0);

        @(posedge Clk);
        #0.5;
        reset = 1'b0;

        // One group of consecutive W lines per test
        idx = 0;
        while (idx < expReg.size() && !timedOut) begin
            curTest      = expTest[idx];
            errorsBefore = errorCount;
            writes       = 0;
            while (idx < expReg.size() && expTest[idx] == curTest && !timedOut) begin
                waitWrite(arrived);
                if (arrived) begin
                    compareValue("wbReg", wordT'(wbReg), wordT'(expReg[idx]));
                    compareValue("wbData", wbData, expData[idx]);
                    writes++;
                    idx++;
                end else begin
                    errorCount++;
                    timedOut = 1'b1;
                    $display("Timeout in test %s: expected write to r%0d never arrived",
                             curTest, expReg[idx]);
                end
            end
            reportTest(curTest, errorsBefore, writes);
        end

        // Skipped paths and the final loop must stay silent
        if (!timedOut) begin
            errorsBefore = errorCount;
            for (idx = 0; idx < drainCycles; idx++) begin
                @(negedge Clk);
                if (wbValid === 1'b1) begin
                    errorCount++;
                    $display("Unexpected write to r%0d with %h after the last expected write",
                             wbReg, wbData);
                end
            end
            reportTest("noExtraWrites", errorsBefore, 0);
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
cpuConfigPkg.sv
isaPkg.sv
pipeInterfaces.sv
fetchUnit.sv
decodeUnit.sv
executeUnit.sv
memoryUnit.sv
pipelineCpu.sv
tbPipelineCpu.sv
